// File: logic/ifetch_defs.svh
//--------------------
// Sizing constants for the instruction fetch front end.
// Include this header wherever one of the macros is used.
//--------------------
`ifndef IFETCH_DEFS_SVH
`define IFETCH_DEFS_SVH

// Hardware threads sharing the fetch unit
`define THREADS 4

// Instruction cache geometry
`define WAYS 2
`define SETS 16
`define LINE_WORDS 4

// Thread t starts at RESET_PC + t * THREAD_PC_STRIDE
`define RESET_PC 32'h0000_0100
`define THREAD_PC_STRIDE 32'h0000_1000

`endif

// File: logic/ifetch_pkg.sv
//--------------------
// Shared types of the fetch front end.
// Modules refer to them as ifetch_pkg::name.
//--------------------
`include "ifetch_defs.svh"

package ifetch_pkg;
    localparam int WORD_BITS = $clog2(`LINE_WORDS);
    localparam int LINE_ADDR_BITS = 30 - WORD_BITS;
    localparam int LINE_BITS = `LINE_WORDS * 32;

    typedef logic [$clog2(`THREADS)-1:0] thread_idx_t;
    typedef logic [`THREADS-1:0] thread_bitmap_t;
    typedef logic [$clog2(`WAYS)-1:0] way_idx_t;
    typedef logic [$clog2(`SETS)-1:0] set_idx_t;
    typedef logic [LINE_ADDR_BITS - $bits(set_idx_t) - 1:0] cache_tag_t;

    typedef struct packed {
        cache_tag_t tag;
        set_idx_t set_idx;
        logic [WORD_BITS-1:0] word_idx;
        logic [1:0] byte_off;
    } fetch_fields_t;

    // Same 32 bits, seen either as a plain address or split for cache lookup
    typedef union packed {
        logic [31:0] raw;
        fetch_fields_t fields;
    } fetch_addr_t;

    typedef struct packed {
        logic requested;
        thread_idx_t thread;
        fetch_addr_t pc;
        cache_tag_t [`WAYS-1:0] tags;
        logic [`WAYS-1:0] valids;
    } tag_result_t;

    typedef struct packed {
        logic valid;
        thread_idx_t thread;
        logic [LINE_ADDR_BITS-1:0] line_addr;
    } miss_report_t;

    typedef struct packed {
        logic en;
        set_idx_t set;
        way_idx_t way;
        cache_tag_t tag;
        logic [LINE_BITS-1:0] data;
    } line_fill_t;

    typedef struct packed {
        logic valid;
        thread_idx_t thread;
        logic [31:0] pc;
        logic [31:0] instruction;
    } fetch_out_t;
endpackage

// File: logic/rr_arbiter.sv
//--------------------
// Round-robin arbiter with one-hot and encoded grant.
// The pointer only moves when update is high.
//--------------------
`timescale 1ns/1ps

module rr_arbiter
#(
    parameter int NUM_REQUESTERS = 4
)
(
    input  logic                              clk,
    input  logic                              reset,
    input  logic [NUM_REQUESTERS-1:0]         request,
    input  logic                              update,
    output logic [NUM_REQUESTERS-1:0]         grant_oh,
    output logic [$clog2(NUM_REQUESTERS)-1:0] grant_idx
);
    localparam int IDX_BITS = $clog2(NUM_REQUESTERS);

    logic [IDX_BITS-1:0] last_idx;

    // Walk from farthest to nearest so the requester right after last_idx wins
    always_comb
    begin
        int cand;
        grant_oh = '0;
        grant_idx = '0;
        for (int i = NUM_REQUESTERS; i >= 1; i--)
        begin
            cand = (int'(last_idx) + i) % NUM_REQUESTERS;
            if (request[cand])
            begin
                grant_oh = NUM_REQUESTERS'(1) << cand;
                grant_idx = IDX_BITS'(cand);
            end
        end
    end

    // Start just before requester 0
    always_ff @(posedge clk, posedge reset)
    begin
        if (reset)
            last_idx <= IDX_BITS'(NUM_REQUESTERS - 1);
        else if (update && |request)
            last_idx <= grant_idx;
    end

    grant_legal: assert property (@(posedge clk) disable iff (reset)
        $onehot0(grant_oh) && (grant_oh & ~request) == '0);
endmodule

// File: logic/ifetch_tag_stage.sv
//--------------------
// Fetch tag stage. Picks a ready thread, advances its PC and
// registers the tag and valid state of the addressed set.
//--------------------
`timescale 1ns/1ps
`include "ifetch_defs.svh"

module ifetch_tag_stage
(
    input  logic                       clk,
    input  logic                       reset,
    input  ifetch_pkg::thread_bitmap_t fetch_en,
    input  logic                       redirect_en,
    input  ifetch_pkg::thread_idx_t    redirect_thread,
    input  logic [31:0]                redirect_pc,
    input  ifetch_pkg::miss_report_t   miss,
    input  ifetch_pkg::line_fill_t     fill,
    input  ifetch_pkg::thread_bitmap_t wake_bitmap,
    output ifetch_pkg::tag_result_t    tag_out
);
    logic [31:0] pc_reg [`THREADS];
    ifetch_pkg::thread_bitmap_t sleeping;
    ifetch_pkg::thread_bitmap_t redirect_oh;
    ifetch_pkg::thread_bitmap_t miss_oh;
    ifetch_pkg::thread_bitmap_t can_fetch;
    ifetch_pkg::thread_bitmap_t grant_oh;
    ifetch_pkg::thread_idx_t grant_idx;
    logic fetch_any;
    ifetch_pkg::fetch_addr_t sel_addr;

    ifetch_pkg::cache_tag_t tag_mem [`WAYS][`SETS];
    logic [`SETS-1:0] line_valid [`WAYS];

    logic req_r;
    ifetch_pkg::thread_idx_t thread_r;
    ifetch_pkg::fetch_addr_t pc_r;
    ifetch_pkg::cache_tag_t [`WAYS-1:0] tags_r;
    logic [`WAYS-1:0] valids_r;

    assign redirect_oh = redirect_en ? ifetch_pkg::thread_bitmap_t'(1) << redirect_thread : '0;
    assign miss_oh = miss.valid ? ifetch_pkg::thread_bitmap_t'(1) << miss.thread : '0;

    // A thread being redirected or reporting a miss this cycle sits out one pick
    assign can_fetch = fetch_en & ~sleeping & ~redirect_oh & ~miss_oh;
    assign fetch_any = |can_fetch;

    rr_arbiter #(
        .NUM_REQUESTERS(`THREADS)
    ) thread_arb_i (
        .clk(clk),
        .reset(reset),
        .request(can_fetch),
        .update(fetch_any),
        .grant_oh(grant_oh),
        .grant_idx(grant_idx)
    );

    assign sel_addr = pc_reg[grant_idx];

    // Redirect wins, then the miss rewind, then the normal advance
    always_ff @(posedge clk, posedge reset)
    begin
        if (reset)
        begin
            for (int t = 0; t < `THREADS; t++)
                pc_reg[t] <= 32'(`RESET_PC + t * `THREAD_PC_STRIDE);
        end
        else
        begin
            for (int t = 0; t < `THREADS; t++)
            begin
                if (redirect_oh[t])
                    pc_reg[t] <= redirect_pc;
                else if (miss_oh[t])
                    pc_reg[t] <= pc_reg[t] - 32'd4;
                else if (grant_oh[t])
                    pc_reg[t] <= pc_reg[t] + 32'd4;
            end
        end
    end

    // Threads sleep from their miss until the fill unit wakes them
    always_ff @(posedge clk, posedge reset)
    begin
        if (reset)
            sleeping <= '0;
        else
            sleeping <= (sleeping | miss_oh) & ~wake_bitmap;
    end

    always_ff @(posedge clk)
    begin
        if (fill.en)
            tag_mem[fill.way][fill.set] <= fill.tag;
    end

    always_ff @(posedge clk, posedge reset)
    begin
        if (reset)
        begin
            for (int w = 0; w < `WAYS; w++)
                line_valid[w] <= '0;
        end
        else if (fill.en)
            line_valid[fill.way][fill.set] <= 1'b1;
    end

    always_ff @(posedge clk, posedge reset)
    begin
        if (reset)
            req_r <= 1'b0;
        else
            req_r <= fetch_any;
    end

    always_ff @(posedge clk)
    begin
        thread_r <= grant_idx;
        pc_r <= sel_addr;
        for (int w = 0; w < `WAYS; w++)
        begin
            // Fill landing on the set being read goes straight to the output
            if (fill.en && fill.way == ifetch_pkg::way_idx_t'(w)
                && fill.set == sel_addr.fields.set_idx)
            begin
                tags_r[w] <= fill.tag;
                valids_r[w] <= 1'b1;
            end
            else
            begin
                tags_r[w] <= tag_mem[w][sel_addr.fields.set_idx];
                valids_r[w] <= line_valid[w][sel_addr.fields.set_idx];
            end
        end
    end

    assign tag_out = '{
        requested: req_r,
        thread: thread_r,
        pc: pc_r,
        tags: tags_r,
        valids: valids_r
    };
endmodule

// File: logic/ifetch_data_stage.sv
//--------------------
// Fetch data stage. Compares tags, reads the hit word into
// the output register and reports misses to the fill unit.
//--------------------
`timescale 1ns/1ps
`include "ifetch_defs.svh"

module ifetch_data_stage
(
    input  logic                     clk,
    input  logic                     reset,
    input  ifetch_pkg::tag_result_t  tag_in,
    input  ifetch_pkg::line_fill_t   fill,
    input  logic                     redirect_en,
    input  ifetch_pkg::thread_idx_t  redirect_thread,
    output ifetch_pkg::miss_report_t miss,
    output ifetch_pkg::fetch_out_t   fetch_out
);
    // Word i of a line sits at bits [32*i +: 32]
    logic [ifetch_pkg::LINE_BITS-1:0] line_mem [`WAYS][`SETS];

    logic [`WAYS-1:0] way_hit;
    ifetch_pkg::way_idx_t hit_way;
    logic hit;
    logic kill;
    logic [ifetch_pkg::LINE_BITS-1:0] hit_line;
    logic [31:0] hit_word;

    logic out_valid_r;
    ifetch_pkg::thread_idx_t out_thread_r;
    logic [31:0] out_pc_r;
    logic [31:0] out_instr_r;

    always_comb
    begin
        hit_way = '0;
        for (int w = 0; w < `WAYS; w++)
        begin
            way_hit[w] = tag_in.valids[w] && tag_in.tags[w] == tag_in.pc.fields.tag;
            if (way_hit[w])
                hit_way = ifetch_pkg::way_idx_t'(w);
        end
    end

    assign hit = |way_hit;

    // Redirect in the same cycle drops this thread's instruction
    assign kill = redirect_en && redirect_thread == tag_in.thread;

    assign hit_line = line_mem[hit_way][tag_in.pc.fields.set_idx];
    assign hit_word = hit_line[tag_in.pc.fields.word_idx * 32 +: 32];

    assign miss = '{
        valid: tag_in.requested && !hit && !kill,
        thread: tag_in.thread,
        line_addr: tag_in.pc.raw[31 -: ifetch_pkg::LINE_ADDR_BITS]
    };

    always_ff @(posedge clk)
    begin
        if (fill.en)
            line_mem[fill.way][fill.set] <= fill.data;
    end

    always_ff @(posedge clk, posedge reset)
    begin
        if (reset)
            out_valid_r <= 1'b0;
        else
            out_valid_r <= tag_in.requested && hit && !kill;
    end

    always_ff @(posedge clk)
    begin
        out_thread_r <= tag_in.thread;
        out_pc_r <= tag_in.pc.raw;
        out_instr_r <= hit_word;
    end

    assign fetch_out = '{
        valid: out_valid_r,
        thread: out_thread_r,
        pc: out_pc_r,
        instruction: out_instr_r
    };

    // Fill unit must never place one line in two ways of a set
    single_way_hit: assert property (@(posedge clk) disable iff (reset)
        tag_in.requested |-> $onehot0(way_hit));
endmodule

// File: logic/icache_fill_unit.sv
//--------------------
// Miss handling. Holds one pending line per thread, fetches it
// over the req/ack handshake, writes the cache and wakes waiters.
//--------------------
`timescale 1ns/1ps
`include "ifetch_defs.svh"

module icache_fill_unit
(
    input  logic                             clk,
    input  logic                             reset,
    input  ifetch_pkg::miss_report_t         miss,
    output logic                             mem_req,
    output logic [31:0]                      mem_addr,
    input  logic                             mem_ack,
    input  logic [ifetch_pkg::LINE_BITS-1:0] mem_line,
    output ifetch_pkg::line_fill_t           fill,
    output ifetch_pkg::thread_bitmap_t       wake_bitmap
);
    ifetch_pkg::thread_bitmap_t pending;
    logic [ifetch_pkg::LINE_ADDR_BITS-1:0] slot_line [`THREADS];
    ifetch_pkg::thread_idx_t grant_idx;
    ifetch_pkg::thread_bitmap_t match;
    logic launch;
    logic ack_wait;
    logic [`SETS-1:0] victim_toggle;
    ifetch_pkg::fetch_addr_t cur_addr;
    logic [ifetch_pkg::LINE_ADDR_BITS-1:0] fill_line;
    logic fill_en_r;
    ifetch_pkg::way_idx_t fill_way_r;
    logic [ifetch_pkg::LINE_BITS-1:0] fill_data_r;
    ifetch_pkg::thread_bitmap_t wake_r;

    assign launch = !mem_req && !ack_wait && |pending;

    rr_arbiter #(
        .NUM_REQUESTERS(`THREADS)
    ) slot_arb_i (
        .clk(clk),
        .reset(reset),
        .request(pending),
        .update(launch),
        .grant_oh(),
        .grant_idx(grant_idx)
    );

    assign fill_line = cur_addr.raw[31 -: ifetch_pkg::LINE_ADDR_BITS];

    // A miss arriving during the fill cycle raced the cache write and is woken too
    always_comb
    begin
        for (int t = 0; t < `THREADS; t++)
            match[t] = (pending[t] && slot_line[t] == fill_line)
                || (miss.valid && miss.thread == ifetch_pkg::thread_idx_t'(t)
                && miss.line_addr == fill_line);
    end

    always_ff @(posedge clk, posedge reset)
    begin
        if (reset)
            pending <= '0;
        else
        begin
            for (int t = 0; t < `THREADS; t++)
            begin
                if (fill_en_r && match[t])
                    pending[t] <= 1'b0;
                else if (miss.valid && miss.thread == ifetch_pkg::thread_idx_t'(t))
                    pending[t] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (miss.valid)
            slot_line[miss.thread] <= miss.line_addr;
    end

    // Handshake: raise req, take the line on ack, then wait for ack to fall
    always_ff @(posedge clk, posedge reset)
    begin
        if (reset)
        begin
            mem_req <= 1'b0;
            ack_wait <= 1'b0;
            fill_en_r <= 1'b0;
            victim_toggle <= '0;
            wake_r <= '0;
        end
        else
        begin
            fill_en_r <= 1'b0;
            wake_r <= fill_en_r ? match : '0;
            if (launch)
                mem_req <= 1'b1;
            if (mem_req && mem_ack)
            begin
                mem_req <= 1'b0;
                ack_wait <= 1'b1;
                fill_en_r <= 1'b1;
                victim_toggle[cur_addr.fields.set_idx] <= ~victim_toggle[cur_addr.fields.set_idx];
            end
            if (ack_wait && !mem_ack)
                ack_wait <= 1'b0;
        end
    end

    always_ff @(posedge clk)
    begin
        if (launch)
            cur_addr.raw <= {slot_line[grant_idx], {(32 - ifetch_pkg::LINE_ADDR_BITS){1'b0}}};
        if (mem_req && mem_ack)
        begin
            fill_data_r <= mem_line;
            fill_way_r <= ifetch_pkg::way_idx_t'(victim_toggle[cur_addr.fields.set_idx]);
        end
    end

    assign mem_addr = cur_addr.raw;
    assign wake_bitmap = wake_r;
    assign fill = '{
        en: fill_en_r,
        set: cur_addr.fields.set_idx,
        way: fill_way_r,
        tag: cur_addr.fields.tag,
        data: fill_data_r
    };

    req_held: assert property (@(posedge clk) disable iff (reset)
        mem_req && !mem_ack |=> mem_req && $stable(mem_addr));
    req_after_ack_low: assert property (@(posedge clk) disable iff (reset)
        $rose(mem_req) |-> !mem_ack);
endmodule

// File: logic/ifetch_top.sv
//--------------------
// Fetch front end top level. Ties the tag stage, data stage
// and fill unit together and exposes the memory handshake.
//--------------------
`timescale 1ns/1ps
`include "ifetch_defs.svh"

module ifetch_top
(
    input  logic                             clk,
    input  logic                             reset,
    input  ifetch_pkg::thread_bitmap_t       fetch_en,
    input  logic                             redirect_en,
    input  ifetch_pkg::thread_idx_t          redirect_thread,
    input  logic [31:0]                      redirect_pc,
    output logic                             mem_req,
    output logic [31:0]                      mem_addr,
    input  logic                             mem_ack,
    input  logic [`LINE_WORDS*32-1:0]        mem_line,
    output ifetch_pkg::fetch_out_t           fetch_out
);
    ifetch_pkg::tag_result_t tag_result;
    ifetch_pkg::miss_report_t miss;
    ifetch_pkg::line_fill_t fill;
    ifetch_pkg::thread_bitmap_t wake_bitmap;

    ifetch_tag_stage tag_stage_i (
        .clk(clk),
        .reset(reset),
        .fetch_en(fetch_en),
        .redirect_en(redirect_en),
        .redirect_thread(redirect_thread),
        .redirect_pc(redirect_pc),
        .miss(miss),
        .fill(fill),
        .wake_bitmap(wake_bitmap),
        .tag_out(tag_result)
    );

    ifetch_data_stage data_stage_i (
        .clk(clk),
        .reset(reset),
        .tag_in(tag_result),
        .fill(fill),
        .redirect_en(redirect_en),
        .redirect_thread(redirect_thread),
        .miss(miss),
        .fetch_out(fetch_out)
    );

    // Misses from the data stage feed the fill unit and the tag stage alike
    icache_fill_unit fill_unit_i (
        .clk(clk),
        .reset(reset),
        .miss(miss),
        .mem_req(mem_req),
        .mem_addr(mem_addr),
        .mem_ack(mem_ack),
        .mem_line(mem_line),
        .fill(fill),
        .wake_bitmap(wake_bitmap)
    );
endmodule

// File: verif/ifetch_tb.sv
//--------------------
// Testbench for the fetch front end. Drives random thread enables
// and redirects, answers line fetches and checks every instruction.
//--------------------
`timescale 1ns/1ps
`include "ifetch_defs.svh"

module ifetch_tb;
    localparam logic [31:0] MEM_PATTERN = 32'hA5A5_A5A5;
    localparam int LINE_BYTES = `LINE_WORDS * 4;
    localparam int MEM_IDLE = 0;
    localparam int MEM_DELAY = 1;
    localparam int MEM_ACKED = 2;
    localparam int MEM_RELEASE = 3;

    logic clk;
    logic reset;
    ifetch_pkg::thread_bitmap_t fetch_en;
    logic redirect_en;
    ifetch_pkg::thread_idx_t redirect_thread;
    logic [31:0] redirect_pc;
    logic mem_req;
    logic [31:0] mem_addr;
    logic mem_ack;
    logic [`LINE_WORDS*32-1:0] mem_line;
    ifetch_pkg::fetch_out_t fetch_out;

    int seed;
    int error_count;
    int tests_passed;
    int tests_failed;
    logic [31:0] expected_pc [`THREADS];
    int delivered [`THREADS];
    int progress_base [`THREADS];
    int mem_state;
    int ack_delay;
    logic prev_req;
    logic [31:0] prev_addr;

    ifetch_top ifetch_top_i (
        .clk(clk),
        .reset(reset),
        .fetch_en(fetch_en),
        .redirect_en(redirect_en),
        .redirect_thread(redirect_thread),
        .redirect_pc(redirect_pc),
        .mem_req(mem_req),
        .mem_addr(mem_addr),
        .mem_ack(mem_ack),
        .mem_line(mem_line),
        .fetch_out(fetch_out)
    );

    initial
    begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Backing memory content, derived from the byte address alone
    function automatic logic [31:0] memory_word(input logic [31:0] addr);
        return addr ^ MEM_PATTERN;
    endfunction

    function automatic logic reached_count(input ifetch_pkg::thread_bitmap_t mask,
                                           input int need);
        logic ok;
        ok = 1'b1;
        for (int t = 0; t < `THREADS; t++)
        begin
            if (mask[t] && delivered[t] < progress_base[t] + need)
                ok = 1'b0;
        end
        return ok;
    endfunction

    task automatic check_fetch();
        ifetch_pkg::thread_idx_t t;
        if (fetch_out.valid)
        begin
            t = fetch_out.thread;
            assert (fetch_out.pc == expected_pc[t])
            else
            begin
                $display("Error fetch_out.pc thread %0d got %h expected %h",
                         t, fetch_out.pc, expected_pc[t]);
                error_count++;
            end
            assert (fetch_out.instruction == memory_word(expected_pc[t]))
            else
            begin
                $display("Error fetch_out.instruction thread %0d got %h expected %h",
                         t, fetch_out.instruction, memory_word(expected_pc[t]));
                error_count++;
            end
            expected_pc[t] = expected_pc[t] + 32'd4;
            delivered[t]++;
        end
    endtask

    // Four-phase order and a stable, line aligned address
    task automatic check_handshake();
        if (mem_req)
        begin
            assert (mem_addr % LINE_BYTES == 0)
            else
            begin
                $display("Error mem_addr %h is not line aligned", mem_addr);
                error_count++;
            end
        end
        if (mem_req && prev_req)
        begin
            assert (mem_addr == prev_addr)
            else
            begin
                $display("Error mem_addr changed from %h to %h during req", prev_addr, mem_addr);
                error_count++;
            end
        end
        if (mem_req && !prev_req)
        begin
            assert (!mem_ack)
            else
            begin
                $display("mem_req rose while mem_ack was still high");
                error_count++;
            end
        end
        if (!mem_req && prev_req)
        begin
            assert (mem_ack)
            else
            begin
                $display("mem_req dropped before mem_ack was raised");
                error_count++;
            end
        end
        prev_req = mem_req;
        prev_addr = mem_addr;
    endtask

    task automatic check_reset_outputs();
        assert (!fetch_out.valid)
        else
        begin
            $display("fetch_out valid was high during or just after reset");
            error_count++;
        end
        assert (!mem_req)
        else
        begin
            $display("mem_req was high during or just after reset");
            error_count++;
        end
    endtask

    // Memory side: ack after 1 to 8 cycles, released 1 to 4 cycles after req falls
    task automatic respond_memory();
        logic [31:0] rnd;
        case (mem_state)
            MEM_IDLE:
            begin
                if (mem_req)
                begin
                    rnd = $random(seed);
                    ack_delay = int'(rnd[2:0]);
                    mem_state = MEM_DELAY;
                end
            end
            MEM_DELAY:
            begin
                if (ack_delay == 0)
                begin
                    for (int i = 0; i < `LINE_WORDS; i++)
                        mem_line[32*i +: 32] = memory_word(mem_addr + 32'(4 * i));
                    mem_ack = 1'b1;
                    mem_state = MEM_ACKED;
                end
                else
                    ack_delay--;
            end
            MEM_ACKED:
            begin
                if (!mem_req)
                begin
                    rnd = $random(seed);
                    ack_delay = int'(rnd[1:0]);
                    mem_state = MEM_RELEASE;
                end
            end
            default:
            begin
                if (ack_delay == 0)
                begin
                    mem_ack = 1'b0;
                    mem_line = '0;
                    mem_state = MEM_IDLE;
                end
                else
                    ack_delay--;
            end
        endcase
    endtask

    // Outputs are checked on the falling edge before new inputs go out
    task automatic run_cycle();
        @(negedge clk);
        check_fetch();
        check_handshake();
        respond_memory();
        redirect_en = 1'b0;
    endtask

    task automatic issue_redirect(input ifetch_pkg::thread_idx_t t, input logic [31:0] pc);
        redirect_en = 1'b1;
        redirect_thread = t;
        redirect_pc = pc;
        expected_pc[t] = pc;
    endtask

    task automatic report_test(input string name, input int start_errors);
        if (error_count == start_errors)
        begin
            tests_passed++;
            $display("%s: ok", name);
        end
        else
        begin
            tests_failed++;
            $display("%s: FAILED with %0d errors", name, error_count - start_errors);
        end
    endtask

    initial
    begin
        int start_errors;
        int wait_cycles;
        logic [31:0] rnd;

        seed = 15;
        error_count = 0;
        tests_passed = 0;
        tests_failed = 0;
        reset = 1'b1;
        fetch_en = '0;
        redirect_en = 1'b0;
        redirect_thread = '0;
        redirect_pc = '0;
        mem_ack = 1'b0;
        mem_line = '0;
        mem_state = MEM_IDLE;
        ack_delay = 0;
        prev_req = 1'b0;
        prev_addr = '0;
        for (int t = 0; t < `THREADS; t++)
        begin
            expected_pc[t] = 32'(`RESET_PC + t * `THREAD_PC_STRIDE);
            delivered[t] = 0;
            progress_base[t] = 0;
        end

        start_errors = error_count;
        repeat (8)
        begin
            run_cycle();
            check_reset_outputs();
        end
        reset = 1'b0;
        repeat (2)
        begin
            run_cycle();
            check_reset_outputs();
        end
        report_test("reset_state", start_errors);

        // Random enables and redirects across the low 64 KB
        start_errors = error_count;
        fetch_en = 4'hF;
        for (int cycle = 0; cycle < 3000; cycle++)
        begin
            run_cycle();
            if (cycle % 8 == 0)
            begin
                rnd = $random(seed);
                fetch_en = rnd[3:0];
            end
            rnd = $random(seed);
            if (rnd[5:0] < 6'd3)
            begin
                rnd = $random(seed);
                issue_redirect(rnd[17:16], {16'h0000, rnd[15:2], 2'b00});
            end
        end
        report_test("random_fetch", start_errors);

        // Two lines with different tags in set 0 must land in both ways
        start_errors = error_count;
        fetch_en = '0;
        repeat (16) run_cycle();
        run_cycle();
        issue_redirect(2'd0, 32'h0002_0000);
        run_cycle();
        issue_redirect(2'd1, 32'h0002_0100);
        run_cycle();
        progress_base = delivered;
        fetch_en = 4'b0011;
        wait_cycles = 0;
        while (!reached_count(4'b0011, 8) && wait_cycles < 2000)
        begin
            run_cycle();
            wait_cycles++;
        end
        assert (reached_count(4'b0011, 8))
        else
        begin
            $display("Timeout while waiting for threads 0 and 1 to fetch from set 0");
            error_count++;
        end
        report_test("same_set_ways", start_errors);

        start_errors = error_count;
        fetch_en = 4'hF;
        progress_base = delivered;
        wait_cycles = 0;
        while (!reached_count(4'hF, 16) && wait_cycles < 4000)
        begin
            run_cycle();
            wait_cycles++;
        end
        assert (reached_count(4'hF, 16))
        else
        begin
            $display("Timeout while waiting for every thread to make progress");
            error_count++;
        end
        report_test("thread_progress", start_errors);

        fetch_en = '0;
        repeat (4) run_cycle();
        $display("%0d tests passed, %0d tests failed", tests_passed, tests_failed);
        if (tests_failed == 0)
            $display("Test completed successfully");
        else
            $display("Test failed");
        $finish;
    end
endmodule

// File: vlog.f
+incdir+logic
logic/ifetch_pkg.sv
logic/rr_arbiter.sv
logic/ifetch_tag_stage.sv
logic/ifetch_data_stage.sv
logic/icache_fill_unit.sv
logic/ifetch_top.sv
verif/ifetch_tb.sv

// File: Bender.yml
package:
  name: ifetch

sources:
  - include_dirs:
      - logic
    files:
      - logic/ifetch_pkg.sv
      - logic/rr_arbiter.sv
      - logic/ifetch_tag_stage.sv
      - logic/ifetch_data_stage.sv
      - logic/icache_fill_unit.sv
      - logic/ifetch_top.sv

  - target: test
    include_dirs:
      - logic
    files:
      - verif/ifetch_tb.sv
